/* Bender.yml */
package:
  name: muldiv_unit

sources:
  # Packages first, then interfaces and modules bottom up
  - rtl/rv_types_pkg.sv
  - rtl/muldiv_pkg.sv
  - rtl/muldiv_if.sv
  - rtl/muldiv_decode.sv
  - rtl/shift_add_mul.sv
  - rtl/restoring_div.sv
  - rtl/muldiv_result.sv
  - rtl/muldiv_unit.sv

  # Testbench, includes the reference model header
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/muldiv_tb.sv

/* bench/muldiv_ref.svh */
// Multiply/divide reference model
`ifndef MULDIV_REF_SVH
`define MULDIV_REF_SVH

// RISC-V M-extension result from double-width signed arithmetic
function automatic rv_types_pkg::xlen_t ref_muldiv(input muldiv_pkg::op_t op,
                                                   input rv_types_pkg::xlen_t a,
                                                   input rv_types_pkg::xlen_t b);
    logic signed [2*rv_types_pkg::XLEN-1:0] sa;
    logic signed [2*rv_types_pkg::XLEN-1:0] sb;
    logic signed [2*rv_types_pkg::XLEN-1:0] ua;
    logic signed [2*rv_types_pkg::XLEN-1:0] ub;
    logic signed [2*rv_types_pkg::XLEN-1:0] wide;
    rv_types_pkg::xlen_t                    min_neg;
    rv_types_pkg::xlen_t                    res;

    // Sign and zero extended copies, all positive-safe in 128 bits
    sa      = {{rv_types_pkg::XLEN{a[rv_types_pkg::XLEN-1]}}, a};
    sb      = {{rv_types_pkg::XLEN{b[rv_types_pkg::XLEN-1]}}, b};
    ua      = {{rv_types_pkg::XLEN{1'b0}}, a};
    ub      = {{rv_types_pkg::XLEN{1'b0}}, b};
    min_neg = {1'b1, {(rv_types_pkg::XLEN-1){1'b0}}};
    wide    = '0;

    case (op)
        muldiv_pkg::MUL:    wide = sa * sb;
        muldiv_pkg::MULH:   wide = sa * sb;
        muldiv_pkg::MULHSU: wide = sa * ub;
        muldiv_pkg::MULHU:  wide = ua * ub;
        // Divide by zero gives all ones, overflow gives the dividend
        muldiv_pkg::DIV: begin
            if (b == '0) begin
                wide = '1;
            end else if (a == min_neg && b == '1) begin
                wide = sa;
            end else begin
                wide = sa / sb;
            end
        end
        muldiv_pkg::DIVU:   wide = (b == '0) ? '1 : ua / ub;
        // Remainder by zero is the dividend, overflow remainder is zero
        muldiv_pkg::REM: begin
            if (b == '0) begin
                wide = sa;
            end else if (a == min_neg && b == '1) begin
                wide = '0;
            end else begin
                wide = sa % sb;
            end
        end
        default:            wide = (b == '0) ? ua : ua % ub;
    endcase

    // High half only for the MULH family
    if (op == muldiv_pkg::MULH || op == muldiv_pkg::MULHSU || op == muldiv_pkg::MULHU) begin
        res = wide[2*rv_types_pkg::XLEN-1:rv_types_pkg::XLEN];
    end else begin
        res = wide[rv_types_pkg::XLEN-1:0];
    end
    return res;
endfunction

`endif

/* bench/muldiv_tb.sv */
// Multiply/divide unit testbench
`timescale 1ns/100ps

module muldiv_tb;

    localparam int W      = rv_types_pkg::XLEN;
    localparam int LAT    = muldiv_pkg::LATENCY;
    localparam int SEED   = 42463;
    localparam int N_RAND = 8;
    // Extremes, random mul, random div, div corners, stray and flush tests
    localparam int N_OPS  = 64 + 4*N_RAND + 4*N_RAND + 12 + 3;
    localparam int WD_CYC = (N_OPS + 2) * (LAT + 3) + 500;

    logic                clk;
    logic                rst;
    logic                flush;
    logic                in_valid;
    muldiv_pkg::op_t     in_op;
    rv_types_pkg::xlen_t in_a;
    rv_types_pkg::xlen_t in_b;
    logic                out_valid;
    rv_types_pkg::xlen_t out_data;
    logic                busy;

    // Outstanding operations, oldest first
    rv_types_pkg::xlen_t exp_data_q[$];
    int                  exp_cyc_q[$];
    muldiv_pkg::op_t     exp_op_q[$];

    rv_types_pkg::xlen_t exp_data;
    int                  exp_cyc;
    muldiv_pkg::op_t     exp_op;
    rv_types_pkg::xlen_t ext_vals[4];
    int                  cycle = 0;
    int                  data_errs = 0;
    int                  lat_errs = 0;
    int                  proto_errs = 0;

    `include "muldiv_ref.svh"

    muldiv_unit muldiv_unit_i (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(in_valid), .in_op(in_op), .in_a(in_a), .in_b(in_b),
        .out_valid(out_valid), .out_data(out_data), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Rising edge count, the latency reference
    always @(posedge clk) cycle <= cycle + 1;

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------

    function automatic rv_types_pkg::xlen_t rand_word();
        return {$urandom, $urandom};
    endfunction

    // Spread of divisor magnitudes, either sign
    function automatic rv_types_pkg::xlen_t rand_divisor();
        rv_types_pkg::xlen_t d;
        d = rand_word() >> ($urandom % W);
        if ($urandom % 2) d = -d;
        return d;
    endfunction

    // Waits for idle, strobes one operation, queues its expected result
    task automatic issue_op(input muldiv_pkg::op_t op, input rv_types_pkg::xlen_t a,
                            input rv_types_pkg::xlen_t b);
        int due;
        @(negedge clk);
        while (busy) @(negedge clk);
        in_valid = 1'b1;
        in_op    = op;
        in_a     = a;
        in_b     = b;
        // Result cycle counted from the in_valid cycle
        due      = cycle + LAT;
        // Accepted on this edge
        @(posedge clk);
        exp_data_q.push_back(ref_muldiv(op, a, b));
        exp_cyc_q.push_back(due);
        exp_op_q.push_back(op);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Strobe while busy, must be dropped
    task automatic stray_strobe(input muldiv_pkg::op_t op, input rv_types_pkg::xlen_t a,
                                input rv_types_pkg::xlen_t b);
        @(negedge clk);
        assert (busy) else begin
            proto_errs++;
            $display("Stray strobe test found the unit idle at %0t", $time);
        end
        in_valid = 1'b1;
        in_op    = op;
        in_a     = a;
        in_b     = b;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // Kill an operation a third of the way through
    task automatic flush_midway(input muldiv_pkg::op_t op, input rv_types_pkg::xlen_t a,
                                input rv_types_pkg::xlen_t b);
        issue_op(op, a, b);
        repeat (LAT / 3) @(negedge clk);
        flush = 1'b1;
        @(posedge clk);
        exp_data_q.delete();
        exp_cyc_q.delete();
        exp_op_q.delete();
        @(negedge clk);
        flush = 1'b0;
        // Quiet window, any out_valid here is unexpected
        repeat (LAT + 4) @(negedge clk);
    endtask

    task automatic drain();
        while (exp_data_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    // ------------------------------------------------------------------------
    // Comparison, outputs sampled mid-cycle
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid) begin
                assert (exp_data_q.size() != 0) else begin
                    proto_errs++;
                    $display("Unexpected out_valid at %0t with nothing outstanding", $time);
                end
                if (exp_data_q.size() != 0) begin
                    exp_data = exp_data_q.pop_front();
                    exp_cyc  = exp_cyc_q.pop_front();
                    exp_op   = exp_op_q.pop_front();
                    assert (out_data === exp_data) else begin
                        data_errs++;
                        $display("FAIL %0t out_data (op %0d): expected %h got %h",
                                 $time, exp_op, exp_data, out_data);
                    end
                    assert (cycle == exp_cyc) else begin
                        lat_errs++;
                        $display("FAIL %0t out_valid cycle: expected %0d got %0d",
                                 $time, exp_cyc, cycle);
                    end
                end
                // Next operation may issue in the result cycle
                assert (!busy) else begin
                    proto_errs++;
                    $display("FAIL %0t busy: expected 0 got %b", $time, busy);
                end
            end else if (exp_data_q.size() != 0) begin
                assert (busy === 1'b1) else begin
                    proto_errs++;
                    $display("FAIL %0t busy: expected 1 got %b", $time, busy);
                end
                assert (cycle < exp_cyc_q[0]) else begin
                    lat_errs++;
                    $display("Result missing at %0t, out_valid never came", $time);
                    void'(exp_data_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                    void'(exp_op_q.pop_front());
                end
            end else begin
                assert (busy === 1'b0) else begin
                    proto_errs++;
                    $display("FAIL %0t busy: expected 0 got %b", $time, busy);
                end
            end
        end
    end

    // Watchdog
    initial begin
        repeat (WD_CYC) @(posedge clk);
        $display("Timeout after %0d cycles, test sequence did not finish", WD_CYC);
        $display("Error counts: data %0d, latency %0d, protocol %0d",
                 data_errs, lat_errs, proto_errs);
        $display("Checks failed");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        void'($urandom(SEED));
        rst      = 1'b1;
        flush    = 1'b0;
        in_valid = 1'b0;
        in_op    = muldiv_pkg::MUL;
        in_a     = '0;
        in_b     = '0;
        // Most negative, -1, 0, 1
        ext_vals[0] = {1'b1, {(W-1){1'b0}}};
        ext_vals[1] = '1;
        ext_vals[2] = '0;
        ext_vals[3] = {{(W-1){1'b0}}, 1'b1};
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Multiply codes on sign extremes, then random
        for (int k = 0; k < 4; k++)
            for (int i = 0; i < 4; i++)
                for (int j = 0; j < 4; j++)
                    issue_op(muldiv_pkg::op_t'(k), ext_vals[i], ext_vals[j]);
        drain();
        for (int k = 0; k < 4; k++)
            for (int n = 0; n < N_RAND; n++)
                issue_op(muldiv_pkg::op_t'(k), rand_word(), rand_word());
        drain();

        // Divide and remainder codes, random signs and magnitudes
        for (int k = 4; k < 8; k++)
            for (int n = 0; n < N_RAND; n++)
                issue_op(muldiv_pkg::op_t'(k), rand_word(), rand_divisor());
        drain();

        // Divide by zero and most negative over -1
        for (int k = 4; k < 8; k++) begin
            issue_op(muldiv_pkg::op_t'(k), rand_word(), '0);
            issue_op(muldiv_pkg::op_t'(k), ext_vals[0], '0);
            issue_op(muldiv_pkg::op_t'(k), ext_vals[0], '1);
        end
        drain();

        // Dropped strobe while busy
        issue_op(muldiv_pkg::MULHSU, rand_word(), rand_word());
        repeat (10) @(negedge clk);
        stray_strobe(muldiv_pkg::DIV, rand_word(), rand_divisor());
        drain();

        // Flush, then a clean operation
        flush_midway(muldiv_pkg::DIV, rand_word(), rand_divisor());
        issue_op(muldiv_pkg::REM, rand_word(), rand_divisor());
        drain();

        $display("Error counts: data %0d, latency %0d, protocol %0d",
                 data_errs, lat_errs, proto_errs);
        if (data_errs + lat_errs + proto_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+bench
rtl/rv_types_pkg.sv
rtl/muldiv_pkg.sv
rtl/muldiv_if.sv
rtl/muldiv_decode.sv
rtl/shift_add_mul.sv
rtl/restoring_div.sv
rtl/muldiv_result.sv
rtl/muldiv_unit.sv
bench/muldiv_tb.sv

/* rtl/muldiv_decode.sv */
// Multiply/divide operation decode
`timescale 1ns/100ps

module muldiv_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                in_valid,
    input  muldiv_pkg::op_t     in_op,
    input  rv_types_pkg::xlen_t in_a,
    input  rv_types_pkg::xlen_t in_b,
    input  logic                busy,
    muldiv_cmd_if.src           cmd
);

    localparam int MSB = rv_types_pkg::XLEN - 1;

    logic accept;
    logic dec_div, dec_as, dec_bs, dec_hi;
    logic sgn_div;

    // New work only while idle
    assign accept = in_valid & ~busy;

    // Funct3 to engine choice, signedness and half select
    always_comb begin
        dec_div = 1'b0;
        dec_as  = 1'b0;
        dec_bs  = 1'b0;
        dec_hi  = 1'b0;
        case (in_op)
            muldiv_pkg::MULH:   begin dec_hi = 1'b1; dec_as = 1'b1; dec_bs = 1'b1; end
            muldiv_pkg::MULHSU: begin dec_hi = 1'b1; dec_as = 1'b1; end
            muldiv_pkg::MULHU:  begin dec_hi = 1'b1; end
            muldiv_pkg::DIV:    begin dec_div = 1'b1; dec_as = 1'b1; dec_bs = 1'b1; end
            muldiv_pkg::DIVU:   begin dec_div = 1'b1; end
            muldiv_pkg::REM:    begin dec_div = 1'b1; dec_as = 1'b1; dec_bs = 1'b1; dec_hi = 1'b1; end
            muldiv_pkg::REMU:   begin dec_div = 1'b1; dec_hi = 1'b1; end
            // Low product half is sign agnostic
            default:            begin dec_hi = 1'b0; end
        endcase
    end

    assign sgn_div = dec_div & dec_as;

    // Launch strobe, one cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            cmd.start <= 1'b0;
        end else begin
            cmd.start <= accept;
        end
    end

    // Operands and controls, held until the next accepted operation
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd.opa      <= in_a;
            cmd.opb      <= in_b;
            cmd.is_div   <= dec_div;
            cmd.a_signed <= dec_as;
            cmd.b_signed <= dec_bs;
            cmd.sel_high <= dec_hi;
            // Zero divisor keeps the all-ones quotient positive
            cmd.neg_q    <= sgn_div & (in_a[MSB] ^ in_b[MSB]) & (|in_b);
            // Remainder follows the dividend sign
            cmd.neg_r    <= sgn_div & in_a[MSB];
        end
    end

endmodule

/* rtl/muldiv_if.sv */
// Multiply/divide internal buses
`timescale 1ns/100ps

// ----------------------------------------------------------------------------
// Decoded command, decode to engines and result formatter
// ----------------------------------------------------------------------------
interface muldiv_cmd_if;
    logic                start;      // One-cycle launch strobe
    logic                is_div;     // Divide engine, else multiply
    logic                a_signed;
    logic                b_signed;
    logic                sel_high;   // High product half or remainder
    logic                neg_q;      // Negate quotient magnitude
    logic                neg_r;      // Negate remainder magnitude
    rv_types_pkg::xlen_t opa;
    rv_types_pkg::xlen_t opb;

    modport src  (output start, is_div, a_signed, b_signed, sel_high, neg_q, neg_r, opa, opb);
    modport sink (input start, is_div, a_signed, b_signed, opa, opb);
    modport fmt  (input sel_high, neg_q, neg_r);
endinterface

// ----------------------------------------------------------------------------
// Engine outcome, engines to result formatter
// ----------------------------------------------------------------------------
interface muldiv_out_if;
    logic                 mul_done;   // One-cycle strobe, product valid
    logic                 div_done;   // One-cycle strobe, quotient/remainder valid
    rv_types_pkg::dxlen_t product;
    rv_types_pkg::xlen_t  quotient;
    rv_types_pkg::xlen_t  remainder;

    modport eng (output mul_done, div_done, product, quotient, remainder);
    modport res (input mul_done, div_done, product, quotient, remainder);
endinterface

/* rtl/muldiv_pkg.sv */
// Multiply/divide unit definitions

package muldiv_pkg;

    // ------------------------------------------------------------------------
    // Operation codes
    // ------------------------------------------------------------------------

    // Encoded as the funct3 field of the OP opcode with funct7 = 0000001
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } op_t;

    // ------------------------------------------------------------------------
    // Engine sequencing
    // ------------------------------------------------------------------------

    // Iterative engine FSM states
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        RUN  = 2'b01,
        DONE = 2'b10
    } seq_state_t;

    // One engine step per operand bit
    localparam int ITERS = rv_types_pkg::XLEN;

    // Counter wide enough to hold ITERS
    typedef logic [6:0] cnt_t;

    // Accept to out_valid, in cycles: decode + ITERS+1 + result
    localparam int LATENCY = rv_types_pkg::XLEN + 3;

endpackage

/* rtl/muldiv_result.sv */
// Multiply/divide result formatter
`timescale 1ns/100ps

module muldiv_result (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    muldiv_cmd_if.fmt           cmd,
    muldiv_out_if.res           res,
    output logic                out_valid,
    output rv_types_pkg::xlen_t out_data
);

    localparam int W = rv_types_pkg::XLEN;

    rv_types_pkg::xlen_t mul_sel;
    rv_types_pkg::xlen_t div_mag;
    rv_types_pkg::xlen_t div_sel;
    logic                div_neg;

    // ------------------------------------------------------------------------
    // Result selection
    // ------------------------------------------------------------------------

    // Product half
    assign mul_sel = cmd.sel_high ? res.product[2*W-1:W] : res.product[W-1:0];

    // Quotient or remainder, with its own sign fix
    assign div_mag = cmd.sel_high ? res.remainder : res.quotient;
    assign div_neg = cmd.sel_high ? cmd.neg_r : cmd.neg_q;
    assign div_sel = div_neg ? -div_mag : div_mag;

    // ------------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= res.mul_done | res.div_done;
        end
    end

    // Payload only loads on a done strobe
    always_ff @(posedge clk) begin
        if (res.mul_done) begin
            out_data <= mul_sel;
        end else if (res.div_done) begin
            out_data <= div_sel;
        end
    end

endmodule

/* rtl/muldiv_unit.sv */
// RV64 M-extension multiply/divide unit
`timescale 1ns/100ps

// Single operation in flight, fixed latency of muldiv_pkg::LATENCY cycles
// from an accepted in_valid to out_valid
module muldiv_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                in_valid,
    input  muldiv_pkg::op_t     in_op,
    input  rv_types_pkg::xlen_t in_a,
    input  rv_types_pkg::xlen_t in_b,
    output logic                out_valid,
    output rv_types_pkg::xlen_t out_data,
    output logic                busy
);

    logic busy_r;
    logic accept;

    muldiv_cmd_if cmd_if ();
    muldiv_out_if out_if ();

    // ------------------------------------------------------------------------
    // Busy tracking
    // ------------------------------------------------------------------------

    // Same acceptance rule as decode, flush kills a same-cycle strobe
    assign accept = in_valid & ~busy & ~flush;

    // New accept wins over the clear from the finishing operation
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy_r <= 1'b0;
        end else if (accept) begin
            busy_r <= 1'b1;
        end else if (out_valid) begin
            busy_r <= 1'b0;
        end
    end

    // Drops in the result cycle so back-to-back issue is possible
    assign busy = busy_r & ~out_valid;

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------

    muldiv_decode decode_i (
        .clk(clk), .rst(rst), .flush(flush),
        .in_valid(in_valid), .in_op(in_op), .in_a(in_a), .in_b(in_b),
        .busy(busy), .cmd(cmd_if.src)
    );

    shift_add_mul mul_i (
        .clk(clk), .rst(rst), .flush(flush), .cmd(cmd_if.sink), .res(out_if.eng)
    );

    restoring_div div_i (
        .clk(clk), .rst(rst), .flush(flush), .cmd(cmd_if.sink), .res(out_if.eng)
    );

    muldiv_result result_i (
        .clk(clk), .rst(rst), .flush(flush),
        .cmd(cmd_if.fmt), .res(out_if.res),
        .out_valid(out_valid), .out_data(out_data)
    );

endmodule

/* rtl/restoring_div.sv */
// Iterative restoring divider
`timescale 1ns/100ps

module restoring_div (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    muldiv_cmd_if.sink  cmd,
    muldiv_out_if.eng   res
);

    localparam int W = rv_types_pkg::XLEN;

    muldiv_pkg::seq_state_t state;
    muldiv_pkg::cnt_t       cnt;

    // High half partial remainder, low half dividend shifting into quotient
    rv_types_pkg::dxlen_t   acc;
    rv_types_pkg::dxlen_t   acc_nxt;
    rv_types_pkg::xlen_t    dvsr;

    rv_types_pkg::xlen_t    mag_a;
    rv_types_pkg::xlen_t    mag_b;
    logic                   launch;
    logic                   last_step;
    logic [W:0]             pr;
    logic [W+1:0]           diff;
    logic                   ge;

    assign launch    = cmd.start & cmd.is_div;
    assign last_step = (cnt == muldiv_pkg::cnt_t'(muldiv_pkg::ITERS - 1));

    // Magnitudes, sign restored later by the formatter
    assign mag_a = (cmd.a_signed && cmd.opa[W-1]) ? -cmd.opa : cmd.opa;
    assign mag_b = (cmd.b_signed && cmd.opb[W-1]) ? -cmd.opb : cmd.opb;

    // ------------------------------------------------------------------------
    // Shift, trial subtract, keep or restore
    // ------------------------------------------------------------------------

    // Remainder shifted left with the next dividend bit, may need W+1 bits
    assign pr   = acc[2*W-1:W-1];
    assign diff = {1'b0, pr} - {2'b00, dvsr};
    assign ge   = ~diff[W+1];

    always_comb begin
        if (ge) begin
            acc_nxt = {diff[W-1:0], acc[W-2:0], 1'b1};
        end else begin
            // Restore, keep shifted remainder
            acc_nxt = {acc[2*W-2:0], 1'b0};
        end
    end

    // Zero divisor always subtracts, giving all-ones and the dividend back
    always_ff @(posedge clk) begin
        if (state == muldiv_pkg::IDLE && launch) begin
            acc  <= {{W{1'b0}}, mag_a};
            dvsr <= mag_b;
        end else if (state == muldiv_pkg::RUN) begin
            acc <= acc_nxt;
        end
    end

    // ------------------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= muldiv_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                muldiv_pkg::IDLE: begin
                    if (launch) begin
                        state <= muldiv_pkg::RUN;
                        cnt   <= '0;
                    end
                end
                muldiv_pkg::RUN: begin
                    cnt <= cnt + 1'b1;
                    if (last_step) begin
                        state <= muldiv_pkg::DONE;
                    end
                end
                default: state <= muldiv_pkg::IDLE;
            endcase
        end
    end

    assign res.div_done  = (state == muldiv_pkg::DONE);
    assign res.quotient  = acc[W-1:0];
    assign res.remainder = acc[2*W-1:W];

endmodule

/* rtl/rv_types_pkg.sv */
// Core register width types

package rv_types_pkg;

    // ------------------------------------------------------------------------
    // Register width
    // ------------------------------------------------------------------------

    // RV64 integer register width
    localparam int XLEN = 64;

    // ------------------------------------------------------------------------
    // Width typedefs
    // ------------------------------------------------------------------------

    // One integer register value
    typedef logic [XLEN-1:0] xlen_t;

    // Full product or shifting dividend, twice the register width
    typedef logic [2*XLEN-1:0] dxlen_t;

endpackage

/* rtl/shift_add_mul.sv */
// Iterative shift-add multiplier
`timescale 1ns/100ps

module shift_add_mul (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    muldiv_cmd_if.sink  cmd,
    muldiv_out_if.eng   res
);

    localparam int W = rv_types_pkg::XLEN;

    muldiv_pkg::seq_state_t state;
    muldiv_pkg::cnt_t       cnt;

    // High half partial product, low half multiplier bits still to consume
    rv_types_pkg::dxlen_t   acc;
    rv_types_pkg::dxlen_t   acc_nxt;

    logic                   launch;
    logic                   last_step;
    logic                   use_sub;
    logic [W:0]             hi_ext;
    logic [W:0]             mc_ext;
    logic [W:0]             sum;

    // Divide commands belong to the other engine
    assign launch    = cmd.start & ~cmd.is_div;
    assign last_step = (cnt == muldiv_pkg::cnt_t'(muldiv_pkg::ITERS - 1));

    // Signed multiplier MSB weighs -2^(W-1), so the last step subtracts
    assign use_sub   = last_step & cmd.a_signed & cmd.b_signed;

    // ------------------------------------------------------------------------
    // Add and shift datapath
    // ------------------------------------------------------------------------

    // One guard bit, sign extended for a signed multiplicand
    assign hi_ext = {cmd.a_signed & acc[2*W-1], acc[2*W-1:W]};
    assign mc_ext = {cmd.a_signed & cmd.opa[W-1], cmd.opa};
    assign sum    = use_sub ? (hi_ext - mc_ext) : (hi_ext + mc_ext);

    always_comb begin
        if (acc[0]) begin
            acc_nxt = {sum, acc[W-1:1]};
        end else begin
            // Plain shift, arithmetic through the guard bit
            acc_nxt = {hi_ext, acc[W-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (state == muldiv_pkg::IDLE && launch) begin
            acc <= {{W{1'b0}}, cmd.opb};
        end else if (state == muldiv_pkg::RUN) begin
            acc <= acc_nxt;
        end
    end

    // ------------------------------------------------------------------------
    // Sequencer, fixed ITERS steps then one DONE cycle
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= muldiv_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                muldiv_pkg::IDLE: begin
                    if (launch) begin
                        state <= muldiv_pkg::RUN;
                        cnt   <= '0;
                    end
                end
                muldiv_pkg::RUN: begin
                    cnt <= cnt + 1'b1;
                    if (last_step) begin
                        state <= muldiv_pkg::DONE;
                    end
                end
                default: state <= muldiv_pkg::IDLE;
            endcase
        end
    end

    assign res.mul_done = (state == muldiv_pkg::DONE);
    assign res.product  = acc;

endmodule
